// ==== exu_cfg.svh ====
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath and address width
`define EXU_XLEN 32

// register index width
`define EXU_RA_W 5

// sequential pc step
`define EXU_PC_STEP 4

// machine-mode csr addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

// environment call from m-mode
`define EXU_ECALL_CAUSE 11

// mstatus bit positions touched by mret
`define EXU_MSTATUS_MIE  3
`define EXU_MSTATUS_MPIE 7

`endif

// ==== exu_pkg.sv ====
`include "exu_cfg.svh"

package exu_pkg;

  // rv32 major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    SLE  = 4'd10,
    SLEU = 4'd11
  } alu_op_e;

  // follows funct3 of the system opcode
  typedef enum logic [3:0] {
    PRIV   = 4'd0,
    CSRRW  = 4'd1,
    CSRRS  = 4'd2,
    CSRRC  = 4'd3,
    CSRRWI = 4'd5,
    CSRRSI = 4'd6,
    CSRRCI = 4'd7
  } sys_fn_e;

  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;
  localparam logic [11:0] PRIV_MRET   = 12'h302;

  typedef union packed {
    logic [`EXU_XLEN-1:0] imm;
    struct packed {
      logic [`EXU_XLEN-17:0] unused;
      logic [11:0]           csr;  // csr address or funct12
      sys_fn_e               sys_fn;
    } sys;
  } exu_imm_u;

  typedef enum logic {
    IDLE = 1'b0,
    WAIT = 1'b1
  } exu_state_e;

  function automatic logic priv_is(exu_imm_u imm, logic [11:0] code);
    return (imm.sys.sys_fn == PRIV) && (imm.sys.csr == code);
  endfunction

endpackage

// ==== exu_alu.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);
  import exu_pkg::*;

  localparam int shamt_w = $clog2(`EXU_XLEN);

  logic [shamt_w-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic               eq;

  assign shamt = b_i[shamt_w-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = (a_i == b_i);

  always_comb begin
    case (op_i)
      ADD:     res_o = a_i + b_i;
      SUB:     res_o = a_i - b_i;
      AND:     res_o = a_i & b_i;
      OR:      res_o = a_i | b_i;
      XOR:     res_o = a_i ^ b_i;
      SLL:     res_o = a_i << shamt;
      SRL:     res_o = a_i >> shamt;
      SRA:     res_o = $signed(a_i) >>> shamt;
      SLT:     res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      SLTU:    res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      SLE:     res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s | eq};  // bge with swapped operands
      SLEU:    res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u | eq};
      default: res_o = '0;
    endcase
  end

endmodule

// ==== exu_issue.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_issue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  prev_valid_i,
  output logic                  ready_o,
  output logic                  valid_o,
  input  logic                  next_ready_i,
  output logic                  commit_o,
  output logic                  lsu_avalid_o,
  input  logic                  lsu_rvalid_i,
  input  logic                  lsu_wready_i,
  input  logic [`EXU_XLEN-1:0]  lsu_rdata_i,
  output logic [`EXU_XLEN-1:0]  mem_rdata_o,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [`EXU_XLEN-1:0]  op1_i,
  input  logic [`EXU_XLEN-1:0]  op2_i,
  input  logic [`EXU_XLEN-1:0]  op_j_i,
  input  logic [`EXU_XLEN-1:0]  imm_i,
  input  logic [6:0]            opcode_i,
  input  logic [3:0]            alu_op_i,
  input  logic [`EXU_RA_W-1:0]  rd_i,
  input  logic                  rwen_i,
  input  logic                  ren_i,
  input  logic                  wen_i,
  output logic [`EXU_XLEN-1:0]  pc_o,
  output logic [`EXU_XLEN-1:0]  src1_o,
  output logic [`EXU_XLEN-1:0]  src2_o,
  output exu_pkg::exu_imm_u     imm_o,
  output exu_pkg::opcode_e      opcode_o,
  output exu_pkg::alu_op_e      alu_op_o,
  output logic [`EXU_XLEN-1:0]  jump_addr_o,
  output logic [`EXU_RA_W-1:0]  rd_o,
  output logic                  rwen_o,
  output logic                  ren_o,
  output logic                  wen_o
);
  import exu_pkg::*;

  exu_state_e state;
  logic       done;  // result ready for writeback
  logic       accept;
  logic       mem_resp;

  assign ready_o  = (state == IDLE);
  assign accept   = prev_valid_i & ready_o;
  assign valid_o  = done;
  assign commit_o = valid_o & next_ready_i;
  assign mem_resp = lsu_avalid_o & ((ren_o & lsu_rvalid_i) | (wen_o & lsu_wready_i));

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      done         <= 1'b0;
      lsu_avalid_o <= 1'b0;
      rwen_o       <= 1'b0;
      ren_o        <= 1'b0;
      wen_o        <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state        <= WAIT;
            done         <= ~(ren_i | wen_i);  // alu ops finish right away
            lsu_avalid_o <= ren_i | wen_i;
            rwen_o       <= rwen_i;
            ren_o        <= ren_i;
            wen_o        <= wen_i;
          end
        end
        WAIT: begin
          if (mem_resp) begin
            lsu_avalid_o <= 1'b0;
            done         <= 1'b1;
          end
          if (commit_o) begin
            state <= IDLE;
            done  <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // instruction payload
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_o        <= pc_i;
      src1_o      <= op1_i;
      src2_o      <= op2_i;
      imm_o.imm   <= imm_i;
      opcode_o    <= opcode_e'(opcode_i);
      alu_op_o    <= alu_op_e'(alu_op_i);
      jump_addr_o <= op_j_i + imm_i;
      rd_o        <= rd_i;
    end
    if (mem_resp && ren_o) begin
      mem_rdata_o <= lsu_rdata_i;
    end
  end

endmodule

// ==== exu_csr.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_csr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 commit_i,
  input  exu_pkg::opcode_e     opcode_i,
  input  exu_pkg::exu_imm_u    imm_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mepc_o,
  output logic [`EXU_XLEN-1:0] mtvec_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] mstatus;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mcause;
  logic                 is_sys;
  logic                 is_ecall;
  logic                 is_mret;
  logic                 is_csr_op;
  logic [11:0]          addr;
  logic [`EXU_XLEN-1:0] wdata;
  logic [`EXU_XLEN-1:0] mstatus_mret;

  assign is_sys    = (opcode_i == SYSTEM);
  assign is_ecall  = is_sys & priv_is(imm_i, PRIV_ECALL);
  assign is_mret   = is_sys & priv_is(imm_i, PRIV_MRET);
  assign is_csr_op = is_sys & (imm_i.sys.sys_fn != PRIV);
  assign addr      = is_mret ? `EXU_CSR_MSTATUS : imm_i.sys.csr;

  always_comb begin
    case (addr)
      `EXU_CSR_MSTATUS: rdata_o = mstatus;
      `EXU_CSR_MTVEC:   rdata_o = mtvec;
      `EXU_CSR_MEPC:    rdata_o = mepc;
      `EXU_CSR_MCAUSE:  rdata_o = mcause;
      default:          rdata_o = '0;
    endcase
  end

  // immediate forms arrive with zimm in src1
  always_comb begin
    case (imm_i.sys.sys_fn)
      CSRRW, CSRRWI: wdata = src1_i;
      CSRRS, CSRRSI: wdata = rdata_o | src1_i;
      CSRRC, CSRRCI: wdata = rdata_o & ~src1_i;
      default:       wdata = rdata_o;
    endcase
  end

  always_comb begin
    mstatus_mret                    = mstatus;
    mstatus_mret[`EXU_MSTATUS_MIE]  = mstatus[`EXU_MSTATUS_MPIE];
    mstatus_mret[`EXU_MSTATUS_MPIE] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (is_ecall) begin
        mcause <= `EXU_XLEN'(`EXU_ECALL_CAUSE);
        mepc   <= pc_i;
      end else if (is_mret) begin
        mstatus <= mstatus_mret;
      end else if (is_csr_op) begin
        case (addr)
          `EXU_CSR_MSTATUS: mstatus <= wdata;
          `EXU_CSR_MTVEC:   mtvec   <= wdata;
          `EXU_CSR_MEPC:    mepc    <= wdata;
          `EXU_CSR_MCAUSE:  mcause  <= wdata;
          default: ;  // unknown csr, dropped
        endcase
      end
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

// ==== exu_resolve.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_resolve (
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  exu_pkg::opcode_e     opcode_i,
  input  exu_pkg::alu_op_e     alu_op_i,
  input  exu_pkg::exu_imm_u    imm_i,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic [`EXU_XLEN-1:0] jump_addr_i,
  input  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  logic [`EXU_XLEN-1:0] mepc_i,
  input  logic [`EXU_XLEN-1:0] mtvec_i,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  logic                 valid_i,
  output logic [`EXU_XLEN-1:0] reg_wdata_o,
  output logic [`EXU_XLEN-1:0] npc_o,
  output logic                 ebreak_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] pc_seq;
  logic                 taken;

  assign pc_seq = pc_i + `EXU_XLEN'(`EXU_PC_STEP);
  // beq compares by subtraction, the rest set a flag
  assign taken  = (alu_op_i == SUB) ? (alu_res_i == '0) : (alu_res_i != '0);

  assign ebreak_o = valid_i & (opcode_i == SYSTEM) & priv_is(imm_i, PRIV_EBREAK);

  always_comb begin
    case (opcode_i)
      LOAD:    reg_wdata_o = mem_rdata_i;
      SYSTEM:  reg_wdata_o = csr_rdata_i;
      default: reg_wdata_o = alu_res_i;
    endcase
  end

  always_comb begin
    npc_o = pc_seq;
    case (opcode_i)
      JAL, JALR: npc_o = jump_addr_i;
      BRANCH: begin
        if (taken) begin
          npc_o = jump_addr_i;
        end
      end
      SYSTEM: begin
        if (priv_is(imm_i, PRIV_ECALL)) begin
          npc_o = mtvec_i;  // trap entry
        end else if (priv_is(imm_i, PRIV_MRET)) begin
          npc_o = mepc_i;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== exu.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 prev_valid_i,
  output logic                 ready_o,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] op1_i,
  input  logic [`EXU_XLEN-1:0] op2_i,
  input  logic [`EXU_XLEN-1:0] op_j_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  logic [6:0]           opcode_i,
  input  logic [3:0]           alu_op_i,
  input  logic [`EXU_RA_W-1:0] rd_i,
  input  logic                 rwen_i,
  input  logic                 ren_i,
  input  logic                 wen_i,
  output logic                 valid_o,
  input  logic                 next_ready_i,
  output logic                 lsu_avalid_o,
  output logic                 lsu_ren_o,
  output logic                 lsu_wen_o,
  output logic [`EXU_XLEN-1:0] lsu_addr_o,
  output logic [`EXU_XLEN-1:0] lsu_wdata_o,
  input  logic [`EXU_XLEN-1:0] lsu_rdata_i,
  input  logic                 lsu_rvalid_i,
  input  logic                 lsu_wready_i,
  output logic [`EXU_XLEN-1:0] reg_wdata_o,
  output logic [`EXU_XLEN-1:0] npc_o,
  output logic [`EXU_RA_W-1:0] rd_o,
  output logic                 rwen_o,
  output logic                 ebreak_o
);
  import exu_pkg::*;

  logic                 commit;
  logic [`EXU_XLEN-1:0] pc;
  logic [`EXU_XLEN-1:0] src1;
  logic [`EXU_XLEN-1:0] src2;
  exu_imm_u             imm;
  opcode_e              opcode;
  alu_op_e              alu_op;
  logic [`EXU_XLEN-1:0] jump_addr;
  logic [`EXU_XLEN-1:0] mem_rdata;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;

  assign lsu_wdata_o = src2;
  assign lsu_addr_o  = jump_addr;  // rs1 + offset for loads and stores

  exu_issue i_issue (
    .clk(clk), .rst(rst),
    .prev_valid_i(prev_valid_i), .ready_o(ready_o),
    .valid_o(valid_o), .next_ready_i(next_ready_i), .commit_o(commit),
    .lsu_avalid_o(lsu_avalid_o), .lsu_rvalid_i(lsu_rvalid_i),
    .lsu_wready_i(lsu_wready_i), .lsu_rdata_i(lsu_rdata_i), .mem_rdata_o(mem_rdata),
    .pc_i(pc_i), .op1_i(op1_i), .op2_i(op2_i), .op_j_i(op_j_i), .imm_i(imm_i),
    .opcode_i(opcode_i), .alu_op_i(alu_op_i), .rd_i(rd_i),
    .rwen_i(rwen_i), .ren_i(ren_i), .wen_i(wen_i),
    .pc_o(pc), .src1_o(src1), .src2_o(src2), .imm_o(imm),
    .opcode_o(opcode), .alu_op_o(alu_op), .jump_addr_o(jump_addr),
    .rd_o(rd_o), .rwen_o(rwen_o), .ren_o(lsu_ren_o), .wen_o(lsu_wen_o)
  );

  exu_alu i_alu (
    .a_i(src1), .b_i(src2), .op_i(alu_op), .res_o(alu_res)
  );

  exu_csr i_csr (
    .clk(clk), .rst(rst), .commit_i(commit),
    .opcode_i(opcode), .imm_i(imm), .src1_i(src1), .pc_i(pc),
    .rdata_o(csr_rdata), .mepc_o(mepc), .mtvec_o(mtvec)
  );

  exu_resolve i_resolve (
    .pc_i(pc), .opcode_i(opcode), .alu_op_i(alu_op), .imm_i(imm),
    .alu_res_i(alu_res), .jump_addr_i(jump_addr), .csr_rdata_i(csr_rdata),
    .mepc_i(mepc), .mtvec_i(mtvec), .mem_rdata_i(mem_rdata), .valid_i(valid_o),
    .reg_wdata_o(reg_wdata_o), .npc_o(npc_o), .ebreak_o(ebreak_o)
  );

endmodule

// ==== exu_sva.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module exu_sva (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ready_i,
  input  logic                 valid_i,
  input  logic                 next_ready_i,
  input  logic                 avalid_i,
  input  exu_pkg::exu_state_e  state_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic [`EXU_XLEN-1:0] jump_addr_i,
  input  logic [`EXU_XLEN-1:0] mem_rdata_i
);
  import exu_pkg::*;

  // one instruction in flight
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(ready_i && valid_i))
    else $error("ready_o and valid_o high in the same cycle");

  a_avalid_in_wait: assert property (@(posedge clk) disable iff (rst)
    avalid_i |-> (state_i == WAIT))
    else $error("lsu_avalid_o high outside WAIT");

  // back-pressure freezes the latched payload
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !next_ready_i) |=> (valid_i && $stable(pc_i) && $stable(src1_i)
      && $stable(src2_i) && $stable(jump_addr_i) && $stable(mem_rdata_i)))
    else $error("stage outputs moved while stalled");

endmodule

bind exu_issue exu_sva i_sva (
  .clk(clk), .rst(rst),
  .ready_i(ready_o), .valid_i(valid_o), .next_ready_i(next_ready_i),
  .avalid_i(lsu_avalid_o), .state_i(state),
  .pc_i(pc_o), .src1_i(src1_o), .src2_i(src2_o),
  .jump_addr_i(jump_addr_o), .mem_rdata_i(mem_rdata_o)
);

// ==== tb_exu.sv ====
`timescale 1ns/10ps
`include "exu_cfg.svh"

module tb_exu;
  import exu_pkg::*;

  localparam int NV          = 24;  // vectors in the file
  localparam int NW          = 9;   // words per vector
  localparam int CYCLE_LIMIT = NV * 20 + 50;

  logic                 clk;
  logic                 rst;
  logic                 prev_valid_i;
  logic                 ready_o;
  logic [`EXU_XLEN-1:0] pc_i;
  logic [`EXU_XLEN-1:0] op1_i;
  logic [`EXU_XLEN-1:0] op2_i;
  logic [`EXU_XLEN-1:0] op_j_i;
  logic [`EXU_XLEN-1:0] imm_i;
  logic [6:0]           opcode_i;
  logic [3:0]           alu_op_i;
  logic [`EXU_RA_W-1:0] rd_i;
  logic                 rwen_i;
  logic                 ren_i;
  logic                 wen_i;
  logic                 valid_o;
  logic                 next_ready_i;
  logic                 lsu_avalid_o;
  logic                 lsu_ren_o;
  logic                 lsu_wen_o;
  logic [`EXU_XLEN-1:0] lsu_addr_o;
  logic [`EXU_XLEN-1:0] lsu_wdata_o;
  logic [`EXU_XLEN-1:0] lsu_rdata_i;
  logic                 lsu_rvalid_i;
  logic                 lsu_wready_i;
  logic [`EXU_XLEN-1:0] reg_wdata_o;
  logic [`EXU_XLEN-1:0] npc_o;
  logic [`EXU_RA_W-1:0] rd_o;
  logic                 rwen_o;
  logic                 ebreak_o;

  logic [31:0] vec_mem [0:NV*NW-1];
  logic [31:0] cur_rdata;  // load data the responder hands back
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  int          n_errors;
  int          vec_errors;
  int          n_bad_vec;
  int          cycle_cnt;
  int          resp_delay;
  logic        resp_is_load;

  exu i_exu (.*);

  always #10 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("CHECK FAILED @%0t: %s expected %h got %h", $time, what, exp, got);
    n_errors++;
    vec_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR @%0t: %s", $time, what);
    n_errors++;
    vec_errors++;
  endtask

  function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS: return m_mstatus;
      `EXU_CSR_MTVEC:   return m_mtvec;
      `EXU_CSR_MEPC:    return m_mepc;
      `EXU_CSR_MCAUSE:  return m_mcause;
      default:          return 32'd0;
    endcase
  endfunction

  task automatic csr_model_write(input logic [11:0] addr, input logic [31:0] data);
    case (addr)
      `EXU_CSR_MSTATUS: m_mstatus = data;
      `EXU_CSR_MTVEC:   m_mtvec   = data;
      `EXU_CSR_MEPC:    m_mepc    = data;
      `EXU_CSR_MCAUSE:  m_mcause  = data;
      default: ;
    endcase
  endtask

  // expected results of a system op, then the model moves on as if committed
  task automatic system_expect(input logic [31:0] pc, input logic [31:0] src1,
                               input logic [31:0] imm, output logic [31:0] wdata,
                               output logic [31:0] npc, output logic brk);
    logic [3:0]  fn;
    logic [11:0] csr;
    logic [31:0] old;
    fn  = imm[3:0];
    csr = imm[15:4];
    npc = pc + 32'd4;
    brk = 1'b0;
    if (fn == 4'd0) begin
      case (csr)
        PRIV_ECALL: begin
          wdata    = csr_model_read(csr);
          npc      = m_mtvec;
          m_mepc   = pc;
          m_mcause = 32'(`EXU_ECALL_CAUSE);
        end
        PRIV_MRET: begin
          wdata        = m_mstatus;
          npc          = m_mepc;
          m_mstatus[3] = m_mstatus[7];  // mie <= mpie
          m_mstatus[7] = 1'b1;
        end
        default: begin
          wdata = csr_model_read(csr);
          brk   = (csr == PRIV_EBREAK);
        end
      endcase
    end else begin
      old   = csr_model_read(csr);
      wdata = old;
      case (fn)
        4'd1, 4'd5: csr_model_write(csr, src1);
        4'd2, 4'd6: csr_model_write(csr, old | src1);
        4'd3, 4'd7: csr_model_write(csr, old & ~src1);
        default: ;
      endcase
    end
  endtask

  task automatic run_vector(input int idx);
    logic [31:0] ctrl;
    logic [31:0] pc;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] exp_wdata;
    logic [31:0] exp_npc;
    logic [31:0] exp_addr;
    logic [31:0] snap_wdata;
    logic [31:0] snap_npc;
    logic        exp_brk;
    logic        is_mem;
    logic        saw_avalid;
    int          lat;
    int          hold;
    ctrl      = vec_mem[idx*NW];
    pc        = vec_mem[idx*NW+1];
    op1       = vec_mem[idx*NW+2];
    op2       = vec_mem[idx*NW+3];
    exp_wdata = vec_mem[idx*NW+7];
    exp_npc   = vec_mem[idx*NW+8];
    exp_addr  = vec_mem[idx*NW+4] + vec_mem[idx*NW+5];  // base plus offset
    exp_brk   = 1'b0;
    is_mem    = ctrl[12] | ctrl[13];
    if (ctrl[6:0] == SYSTEM) begin
      system_expect(pc, op1, vec_mem[idx*NW+5], exp_wdata, exp_npc, exp_brk);
    end
    vec_errors = 0;
    cur_rdata  = vec_mem[idx*NW+6];

    @(posedge clk);
    prev_valid_i <= 1'b1;
    pc_i         <= pc;
    op1_i        <= op1;
    op2_i        <= op2;
    op_j_i       <= vec_mem[idx*NW+4];
    imm_i        <= vec_mem[idx*NW+5];
    opcode_i     <= ctrl[6:0];
    alu_op_i     <= ctrl[11:8];
    ren_i        <= ctrl[12];
    wen_i        <= ctrl[13];
    rwen_i       <= ctrl[14];
    rd_i         <= ctrl[28:24];
    do @(negedge clk); while (!ready_o);
    @(posedge clk);  // acceptance edge
    prev_valid_i <= 1'b0;

    lat        = 0;
    saw_avalid = 1'b0;
    do begin
      @(negedge clk);
      lat++;
      if (lsu_avalid_o) begin
        saw_avalid = 1'b1;
        if (!is_mem) report_problem("lsu_avalid_o raised by a non-memory instruction");
        if (lsu_wdata_o !== op2) report_mismatch("lsu_wdata_o", op2, lsu_wdata_o);
        if (lsu_addr_o !== exp_addr) report_mismatch("lsu_addr_o", exp_addr, lsu_addr_o);
        if (lsu_ren_o !== ctrl[12]) report_mismatch("lsu_ren_o", 32'(ctrl[12]), 32'(lsu_ren_o));
        if (lsu_wen_o !== ctrl[13]) report_mismatch("lsu_wen_o", 32'(ctrl[13]), 32'(lsu_wen_o));
      end
    end while (!valid_o);

    if (!is_mem && lat != 1) report_problem("valid_o did not follow acceptance by one cycle");
    if (is_mem && !saw_avalid) report_problem("memory request never raised lsu_avalid_o");
    if (reg_wdata_o !== exp_wdata) report_mismatch("reg_wdata_o", exp_wdata, reg_wdata_o);
    if (npc_o !== exp_npc) report_mismatch("npc_o", exp_npc, npc_o);
    if (rd_o !== ctrl[28:24]) report_mismatch("rd_o", 32'(ctrl[28:24]), 32'(rd_o));
    if (rwen_o !== ctrl[14]) report_mismatch("rwen_o", 32'(ctrl[14]), 32'(rwen_o));
    if (ebreak_o !== exp_brk) report_mismatch("ebreak_o", 32'(exp_brk), 32'(ebreak_o));

    // writeback stalls for a while
    snap_wdata = reg_wdata_o;
    snap_npc   = npc_o;
    hold       = exp_brk ? 3 : int'($urandom % 4);
    repeat (hold) begin
      @(negedge clk);
      if (!valid_o || reg_wdata_o !== snap_wdata || npc_o !== snap_npc
          || ebreak_o !== exp_brk) begin
        report_problem("outputs changed while next_ready_i was low");
      end
    end
    @(posedge clk);
    next_ready_i <= 1'b1;
    @(posedge clk);  // transfer edge
    next_ready_i <= 1'b0;

    if (vec_errors != 0) n_bad_vec++;
    $display("vector %0d group %0d: %s", idx, ctrl[19:16], (vec_errors == 0) ? "ok" : "mismatch");
  endtask

  // memory side answers each request once, after a short random gap
  always begin
    @(negedge clk);
    if (lsu_avalid_o && !rst) begin
      resp_is_load = lsu_ren_o;
      resp_delay   = int'($urandom % 4);
      repeat (resp_delay) @(posedge clk);
      @(posedge clk);
      lsu_rvalid_i <= resp_is_load;
      lsu_wready_i <= ~resp_is_load;
      lsu_rdata_i  <= resp_is_load ? cur_rdata : 32'd0;
      @(posedge clk);
      lsu_rvalid_i <= 1'b0;
      lsu_wready_i <= 1'b0;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    pc_i         = '0;
    op1_i        = '0;
    op2_i        = '0;
    op_j_i       = '0;
    imm_i        = '0;
    opcode_i     = '0;
    alu_op_i     = '0;
    rd_i         = '0;
    rwen_i       = 1'b0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    next_ready_i = 1'b0;
    lsu_rdata_i  = '0;
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    m_mstatus    = '0;
    m_mtvec      = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    n_errors     = 0;
    n_bad_vec    = 0;
    void'($urandom(32'he2c2_6bce));
    $readmemh("exu_vectors.txt", vec_mem);

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NV; i++) begin
      run_vector(i);
    end

    $display("%0d vectors run, %0d with mismatches, %0d errors", NV, n_bad_vec, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== exu_vectors.txt ====
// ctrl pc op1 op2 op_j imm rdata exp_wdata exp_npc; ctrl = rd[28:24] group[19:16] rwen[14]
// wen[13] ren[12] alu_op[11:8] opcode[6:0]; system ops take their expected values from the csr model
01014033 00000100 00000005 00000007 00000000 00000000 00000000 0000000c 00000104
02014133 00000104 00000010 00000020 00000000 00000000 00000000 fffffff0 00000108
03014713 00000108 80000000 00000004 00000000 00000000 00000000 f8000000 0000010c
04014833 0000010c ffffffff 00000001 00000000 00000000 00000000 00000001 00000110
00020163 00000110 00000055 00000055 00000110 00000020 00000000 00000000 00000130
00020163 00000114 00000055 00000056 00000114 00000040 00000000 ffffffff 00000118
00020863 00000118 fffffffe 00000003 00000118 fffffff0 00000000 00000001 00000108
00020b63 0000011c 00000005 00000003 0000011c 00000008 00000000 00000000 00000120
00020963 00000140 00000003 fffffff0 00000200 00000040 00000000 00000001 00000240
00020a63 00000144 fffffffb fffffffb 00000300 00000000 00000000 00000001 00000300
0102406f 00000120 00000120 00000004 00000120 00000100 00000000 00000124 00000220
01024067 00000220 00000220 00000004 00001000 00000010 00000000 00000224 00001010
02035003 00001010 00000000 deadbeef 00002000 00000008 cafef00d cafef00d 00001014
00032023 00001014 00000000 12345678 00002000 00000004 00000000 12345678 00001018
03035003 00001018 00000000 00000000 00002000 0000000c 0badf00d 0badf00d 0000101c
05044073 0000101c 00000800 00000000 00000000 00003051 00000000 00000000 00000000
05044073 00001020 00000033 00000000 00000000 00003052 00000000 00000000 00000000
05044073 00001024 00000003 00000000 00000000 00003053 00000000 00000000 00000000
00050073 00001028 00000000 00000000 00000000 00000000 00000000 00000000 00000000
06054073 00000830 00000000 00000000 00000000 00003412 00000000 00000000 00000000
06054073 00000834 00000000 00000000 00000000 00003422 00000000 00000000 00000000
00050073 00000838 00000000 00000000 00000000 00003020 00000000 00000000 00000000
06054073 00001028 00000000 00000000 00000000 00003002 00000000 00000000 00000000
00060073 0000102c 00000000 00000000 00000000 00000010 00000000 00000000 00000000

// ==== filelist.f ====
+incdir+.
exu_pkg.sv
exu_alu.sv
exu_issue.sv
exu_csr.sv
exu_resolve.sv
exu.sv
exu_sva.sv
tb_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
